//--- tb.f
pad_proto_pkg.sv
pad_event_pkg.sv
pad_poll_sequencer.sv
pad_change_decoder.sv
pad_event_queue.sv
pad_input_top.sv
pad_input_properties.sv
tb_pad_input.sv

//--- Makefile
# Verilator build of the pad input testbench

SOURCES := $(shell cat tb.f)

# rebuilt only when a source or the file list changes
obj_dir/Vtb_pad_input: $(SOURCES) tb.f
	verilator --binary --assert -Wno-fatal --top-module tb_pad_input -f tb.f

# the error limit lets assertion failures reach the closing summary
run: obj_dir/Vtb_pad_input
	./obj_dir/Vtb_pad_input +verilator+error+limit+1000 | tee sim.log
	@if grep -q "Some tests failed" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "All tests passed" sim.log; then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- tb_pad_input.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pad_input
	import pad_proto_pkg::*, pad_event_pkg::*;
;

	// short poll period keeps the run small
	localparam int poll_latch = 12;
	localparam int poll_half_bit = 6;
	localparam int poll_period = 160;
	localparam int queue_entries = 4;
	localparam int start_credits = 4;

	// consumer credit behaviour
	localparam logic [1:0] credit_always = 2'd0;
	localparam logic [1:0] credit_hold = 2'd1;
	localparam logic [1:0] credit_random = 2'd2;

	logic clock = 1'b0;
	logic reset = 1'b1;
	logic pad_data = 1'b1;
	logic credit_return = 1'b0;
	logic pad_latch;
	logic pad_pulse;
	logic frame_valid;
	logic event_valid;
	pad_frame_t frame;
	pad_event_t event_out;

	// test control, driven on the rising edge
	logic strict = 1'b0;
	logic [1:0] credit_mode = credit_always;
	logic timed_out = 1'b0;

	// pad and consumer model
	logic [31:0] rng = 32'd7;
	logic [7:0] pad_buttons = '0;
	logic [7:0] shreg = '1;
	logic [7:0] loaded_q [$];
	logic model_prev_latch = 1'b0;
	logic model_prev_pulse = 1'b1;
	logic [7:0] tb_target = '0;
	logic [7:0] tb_reported = '0;
	frame_seq_t exp_seq = '0;
	frame_seq_t target_seq = '0;
	int owed = 0;

	// waveform monitor
	logic wave_prev_latch = 1'b0;
	logic wave_prev_pulse = 1'b1;
	logic rise_seen = 1'b0;
	logic fall_seen = 1'b0;
	int high_len = 0;
	int since_fall = 0;
	int since_rise = 0;
	int pulse_rises = 0;

	int wave_errors = 0;
	int frame_errors = 0;
	int event_errors = 0;
	int flow_errors = 0;

	always #50 clock = ~clock;

	pad_input_top #(
		.latch_cycles(poll_latch),
		.half_bit_cycles(poll_half_bit),
		.poll_period_cycles(poll_period),
		.queue_depth(queue_entries),
		.consumer_credits(start_credits)
	) dut_i (
		.clock(clock),
		.reset(reset),
		.pad_data(pad_data),
		.pad_latch(pad_latch),
		.pad_pulse(pad_pulse),
		.frame_valid(frame_valid),
		.frame(frame),
		.event_valid(event_valid),
		.event_out(event_out),
		.credit_return(credit_return)
	);

	bind pad_event_queue pad_input_properties #(
		.queue_depth(queue_depth),
		.consumer_credits(consumer_credits)
	) props_i (
		.clock(clock),
		.reset(reset),
		.push(push),
		.event_valid(event_valid),
		.credit_up(credit_up),
		.credit_return(credit_return),
		.count(count)
	);

	function automatic logic [31:0] lcg_step(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	// A sits in bit 7 and goes first, -1 when nothing is pending
	function automatic int top_bit(input logic [7:0] pending);
		int pos;
		pos = -1;
		for (int i = 7; i >= 0; i--)
			if (pending[i] && pos < 0)
				pos = i;
		return pos;
	endfunction

	task automatic show_mismatch(input string name, input int expected, input int actual);
		$display("error %s: expected %0h, actual %0h", name, expected, actual);
	endtask

	////////////////////////////////////////////////////////////
	// latch and pulse waveform
	////////////////////////////////////////////////////////////

	always @(posedge clock)
	begin
		if (reset)
		begin
			wave_prev_latch = 1'b0;
			wave_prev_pulse = 1'b1;
			rise_seen = 1'b0;
			fall_seen = 1'b0;
		end
		else
		begin
			since_fall++;
			since_rise++;
			if (pad_latch)
				high_len++;
			if (pad_latch && !pad_pulse)
			begin
				$display("pad_pulse low while pad_latch is high");
				wave_errors++;
			end
			// start of a poll
			if (pad_latch && !wave_prev_latch)
			begin
				if (rise_seen && since_rise != poll_period)
				begin
					show_mismatch("poll_period", poll_period, since_rise);
					wave_errors++;
				end
				if (fall_seen && pulse_rises != 8)
				begin
					show_mismatch("pulse_count", 8, pulse_rises);
					wave_errors++;
				end
				since_rise = 0;
				high_len = 1;
				rise_seen = 1'b1;
			end
			if (!pad_latch && wave_prev_latch)
			begin
				if (high_len != poll_latch)
				begin
					show_mismatch("latch_width", poll_latch, high_len);
					wave_errors++;
				end
				since_fall = 0;
				pulse_rises = 0;
				fall_seen = 1'b1;
			end
			else if (!pad_latch && pad_pulse != wave_prev_pulse)
			begin
				// edges on phase boundaries only, rising on odd phases
				if (since_fall % poll_half_bit != 0 || since_fall > 15 * poll_half_bit ||
					(since_fall / poll_half_bit) % 2 != int'(pad_pulse))
				begin
					$display("pad_pulse edge %0d cycles after latch fell", since_fall);
					wave_errors++;
				end
				if (pad_pulse)
					pulse_rises++;
			end
			wave_prev_latch = pad_latch;
			wave_prev_pulse = pad_pulse;
		end
	end

	////////////////////////////////////////////////////////////
	// pad model, consumer and checks on frames and events
	////////////////////////////////////////////////////////////

	task automatic check_frame();
		logic [7:0] expect_buttons;
		expect_buttons = tb_target;
		exp_seq = exp_seq + 8'd1;
		if (loaded_q.size() == 0)
		begin
			$display("frame_valid without a loaded poll");
			frame_errors++;
		end
		else
		begin
			expect_buttons = loaded_q.pop_front();
			if (frame.buttons != expect_buttons)
			begin
				show_mismatch("frame_buttons", expect_buttons, frame.buttons);
				frame_errors++;
			end
		end
		if (frame.seq != exp_seq)
		begin
			show_mismatch("frame_seq", exp_seq, frame.seq);
			frame_errors++;
		end
		tb_target = expect_buttons;
		target_seq = exp_seq;
	endtask

	task automatic check_event();
		int bit_pos;
		int expect_bit;
		event_kind_e expect_kind;
		bit_pos = int'(event_out.button);
		expect_bit = top_bit(tb_target ^ tb_reported);
		expect_kind = tb_target[bit_pos] ? ev_press : ev_release;
		// consumer credit is what was given minus what is still owed
		if (owed >= start_credits)
		begin
			$display("event_valid with no consumer credit left");
			event_errors++;
		end
		if (tb_reported[bit_pos] == (event_out.kind == ev_press))
		begin
			$display("event on button %0d does not change the reported state", bit_pos);
			event_errors++;
		end
		if (strict && expect_bit < 0)
		begin
			$display("event on button %0d with no pending change", bit_pos);
			event_errors++;
		end
		else if (strict)
		begin
			if (bit_pos != expect_bit)
			begin
				show_mismatch("event_button", expect_bit, bit_pos);
				event_errors++;
			end
			if (event_out.kind != expect_kind)
			begin
				show_mismatch("event_kind", expect_kind, event_out.kind);
				event_errors++;
			end
			if (event_out.seq != target_seq)
			begin
				show_mismatch("event_seq", target_seq, event_out.seq);
				event_errors++;
			end
		end
		tb_reported[bit_pos] = (event_out.kind == ev_press);
	endtask

	always @(posedge clock)
	begin
		if (reset)
		begin
			model_prev_latch = 1'b0;
			model_prev_pulse = 1'b1;
			loaded_q.delete();
			exp_seq = '0;
			tb_target = '0;
			tb_reported = '0;
			owed = 0;
			pad_data <= 1'b1;
			credit_return <= 1'b0;
		end
		else
		begin
			// events belong to the older target, so they go first
			if (event_valid)
				check_event();
			if (frame_valid)
				check_frame();
			if (event_valid)
				owed++;
			if (credit_return)
				owed--;
			// 4021 shift register, new buttons for each poll
			if (pad_latch && !model_prev_latch)
			begin
				rng = lcg_step(rng);
				pad_buttons = rng[30:23];
				loaded_q.push_back(pad_buttons);
			end
			if (pad_latch)
				shreg = ~pad_buttons;
			else if (pad_pulse && !model_prev_pulse)
				shreg = {shreg[6:0], 1'b0};
			pad_data <= shreg[7];
			model_prev_latch = pad_latch;
			model_prev_pulse = pad_pulse;
			// return only credits that are owed
			rng = lcg_step(rng);
			case (credit_mode)
				credit_always: credit_return <= (owed > 0);
				credit_random: credit_return <= (owed > 0) && rng[27];
				default: credit_return <= 1'b0;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	task automatic set_mode(input logic strict_value, input logic [1:0] mode_value);
		@(posedge clock);
		strict <= strict_value;
		credit_mode <= mode_value;
	endtask

	task automatic wait_frames(input int n);
		int seen;
		int cycles;
		seen = 0;
		cycles = 0;
		while (seen < n && !timed_out)
		begin
			@(negedge clock);
			cycles++;
			if (frame_valid)
			begin
				seen++;
				cycles = 0;
			end
			else if (cycles > 2 * poll_period)
			begin
				$display("timeout waiting for frame_valid");
				timed_out = 1'b1;
			end
		end
	endtask

	// all events applied to the reported state give the last frame
	task automatic wait_converged();
		int cycles;
		cycles = 0;
		// the model takes the new frame on the next rising edge
		@(negedge clock);
		while (tb_reported != tb_target && cycles <= 100 && !timed_out)
		begin
			@(negedge clock);
			cycles++;
		end
		if (cycles > 100)
		begin
			show_mismatch("converge", tb_target, tb_reported);
			flow_errors++;
		end
	endtask

	// nothing may come out before the first complete poll
	task automatic wait_first_frame();
		int cycles;
		cycles = 0;
		while (!frame_valid && !timed_out)
		begin
			@(negedge clock);
			cycles++;
			if (event_valid)
			begin
				$display("event_valid before the first frame after reset");
				flow_errors++;
			end
			if (cycles > 2 * poll_period)
			begin
				$display("timeout waiting for the first frame after reset");
				timed_out = 1'b1;
			end
		end
		if (frame_valid && cycles != poll_latch + 14 * poll_half_bit + 2)
		begin
			show_mismatch("first_frame", poll_latch + 14 * poll_half_bit + 2, cycles);
			flow_errors++;
		end
	endtask

	task automatic run_phases();
		repeat (16) @(posedge clock);
		reset <= 1'b0;
		strict <= 1'b1;
		// free flowing consumer
		for (int i = 0; i < 6; i++)
		begin
			wait_frames(1);
			wait_converged();
		end
		// back-pressure, then random returns, then drain
		set_mode(1'b0, credit_hold);
		wait_frames(3);
		set_mode(1'b0, credit_random);
		wait_frames(2);
		set_mode(1'b0, credit_always);
		wait_frames(1);
		wait_converged();
		// second reset in the middle of a poll
		repeat (poll_period / 2) @(posedge clock);
		reset <= 1'b1;
		repeat (16) @(posedge clock);
		reset <= 1'b0;
		strict <= 1'b1;
		wait_first_frame();
		wait_converged();
		for (int i = 0; i < 3; i++)
		begin
			wait_frames(1);
			wait_converged();
		end
	endtask

	task automatic finish_run();
		int failures;
		failures = dut_i.queue_i.props_i.failures;
		$display("errors: waveform %0d, frame %0d, event %0d, flow %0d, timeout %0d, assertion %0d",
			wave_errors, frame_errors, event_errors, flow_errors, int'(timed_out), failures);
		if (wave_errors + frame_errors + event_errors + flow_errors + failures == 0 && !timed_out)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	endtask

	initial
	begin
		run_phases();
		finish_run();
	end

endmodule

`default_nettype wire

//--- pad_input_properties.sv
`timescale 1ns/1ps
`default_nettype none

module pad_input_properties
#(
	parameter int queue_depth = 4,
	parameter int consumer_credits = 4
)
(
	input  wire logic clock,
	input  wire logic reset,
	input  wire logic push,
	input  wire logic event_valid,
	input  wire logic credit_up,
	input  wire logic credit_return,
	input  wire logic [$clog2(queue_depth + 1)-1:0] count
);

	localparam int count_width = $clog2(queue_depth + 1);

	// number of failed assertions
	int failures = 0;

	// consumer credits seen from the outside
	int consumer_left;
	// entries pushed and not yet given back upstream
	int held;

	////////////////////////////////////////////////////////////
	// credit bookkeeping
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			consumer_left <= consumer_credits;
			held <= 0;
		end
		else
		begin
			consumer_left <= consumer_left - int'(event_valid) + int'(credit_return);
			held <= held + int'(push) - int'(credit_up);
		end
	end

	////////////////////////////////////////////////////////////
	// queue credit rules
	////////////////////////////////////////////////////////////

	// consumer credit must be held before an event leaves
	valid_with_credit_a: assert property (@(posedge clock) disable iff (reset)
		event_valid |-> consumer_left > 0)
	else
	begin
		failures++;
		$error("event_valid with no consumer credit");
	end

	// the decoder must not push into a full queue
	push_not_full_a: assert property (@(posedge clock) disable iff (reset)
		push |-> count != count_width'(queue_depth))
	else
	begin
		failures++;
		$error("push into a full queue");
	end

	// one credit upstream per dequeue, never more
	credit_per_dequeue_a: assert property (@(posedge clock) disable iff (reset)
		held == int'(count))
	else
	begin
		failures++;
		$error("credit_up does not match the dequeues");
	end

endmodule

`default_nettype wire

//--- pad_input_top.sv
`timescale 1ns/1ps
`default_nettype none

module pad_input_top
	import pad_proto_pkg::*, pad_event_pkg::*;
#(
	parameter int latch_cycles = 12,
	parameter int half_bit_cycles = 6,
	parameter int poll_period_cycles = 400,
	parameter int queue_depth = 4,
	parameter int consumer_credits = 4
)
(
	input  wire logic clock,
	input  wire logic reset,
	// pad side
	input  wire logic pad_data,
	output logic pad_latch,
	output logic pad_pulse,
	// latest snapshot
	output logic frame_valid,
	output pad_frame_t frame,
	// consumer side
	output logic event_valid,
	output pad_event_t event_out,
	input  wire logic credit_return
);

	// decoder to queue
	logic push;
	pad_event_t event_in;
	logic credit_up;

	////////////////////////////////////////////////////////////
	// poll, decode, queue
	////////////////////////////////////////////////////////////

	pad_poll_sequencer #(
		.latch_cycles(latch_cycles),
		.half_bit_cycles(half_bit_cycles),
		.poll_period_cycles(poll_period_cycles)
	) sequencer_i (
		.clock(clock),
		.reset(reset),
		.pad_data(pad_data),
		.pad_latch(pad_latch),
		.pad_pulse(pad_pulse),
		.frame_valid(frame_valid),
		.frame(frame)
	);

	// snapshots go straight on, no back-pressure here
	pad_change_decoder #(
		.queue_depth(queue_depth)
	) decoder_i (
		.clock(clock),
		.reset(reset),
		.frame_valid(frame_valid),
		.frame(frame),
		.credit_up(credit_up),
		.push(push),
		.event_in(event_in)
	);

	pad_event_queue #(
		.queue_depth(queue_depth),
		.consumer_credits(consumer_credits)
	) queue_i (
		.clock(clock),
		.reset(reset),
		.push(push),
		.event_in(event_in),
		.credit_up(credit_up),
		.credit_return(credit_return),
		.event_valid(event_valid),
		.event_out(event_out)
	);

endmodule

`default_nettype wire

//--- pad_event_queue.sv
`timescale 1ns/1ps
`default_nettype none

module pad_event_queue
	import pad_event_pkg::*;
#(
	parameter int queue_depth = 4,
	parameter int consumer_credits = 4
)
(
	input  wire logic clock,
	input  wire logic reset,
	input  wire logic push,
	input  wire pad_event_t event_in,
	output logic credit_up,
	input  wire logic credit_return,
	output logic event_valid,
	output pad_event_t event_out
);

	localparam int ptr_width = (queue_depth > 1) ? $clog2(queue_depth) : 1;
	localparam int count_width = $clog2(queue_depth + 1);
	localparam int credit_width = $clog2(consumer_credits + 1);

	pad_event_t mem [queue_depth];
	logic [ptr_width-1:0] wr_ptr;
	logic [ptr_width-1:0] rd_ptr;
	logic [count_width-1:0] count;
	logic [credit_width-1:0] credits;
	logic pop;

	////////////////////////////////////////////////////////////
	// consumer side
	////////////////////////////////////////////////////////////

	// oldest entry leaves when the consumer has a credit for it
	assign pop = (count != '0) && (credits != '0);
	assign event_valid = pop;
	assign event_out = mem[rd_ptr];

	// every dequeue frees one entry for the decoder
	assign credit_up = pop;

	////////////////////////////////////////////////////////////
	// circular buffer
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (push)
			mem[wr_ptr] <= event_in;
	end

	// pointers wrap at depth, which need not be a power of two
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= (wr_ptr == ptr_width'(queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == ptr_width'(queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
		end
	end

	// occupancy
	always_ff @(posedge clock)
	begin
		if (reset)
			count <= '0;
		else
		begin
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// consumer credits
	always_ff @(posedge clock)
	begin
		if (reset)
			credits <= credit_width'(consumer_credits);
		else
		begin
			case ({pop, credit_return})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- pad_change_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module pad_change_decoder
	import pad_proto_pkg::*, pad_event_pkg::*;
#(
	parameter int queue_depth = 4
)
(
	input  wire logic clock,
	input  wire logic reset,
	input  wire logic frame_valid,
	input  wire pad_frame_t frame,
	input  wire logic credit_up,
	output logic push,
	output pad_event_t event_in
);

	localparam int credit_width = $clog2(queue_depth + 1);

	// latest frame and what has been reported so far
	button_state_t target;
	button_state_t reported;
	frame_seq_t target_seq;
	logic [credit_width-1:0] credits;

	logic [num_buttons-1:0] pending;
	logic [2:0] pick;

	////////////////////////////////////////////////////////////
	// change selection
	////////////////////////////////////////////////////////////

	assign pending = target ^ reported;

	// priority encoder, A first
	always_comb
	begin
		pick = 3'd0;
		for (int i = 0; i < num_buttons; i++)
		begin
			if (pending[i])
				pick = 3'(i);
		end
	end

	// one event per cycle while the queue has room
	assign push = (pending != '0) && (credits != '0);

	// press if the target holds the button down
	assign event_in.kind = target[pick] ? ev_press : ev_release;
	assign event_in.button = button_index_e'(pick);
	assign event_in.seq = target_seq;

	////////////////////////////////////////////////////////////
	// state
	////////////////////////////////////////////////////////////

	// a new frame simply replaces the target
	// intermediate transitions may be dropped
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			target <= '0;
			target_seq <= '0;
			reported <= '0;
		end
		else
		begin
			if (frame_valid)
			begin
				target <= frame.buttons;
				target_seq <= frame.seq;
			end
			if (push)
				reported[pick] <= target[pick];
		end
	end

	// queue credits, minus one per push, plus one per dequeue
	always_ff @(posedge clock)
	begin
		if (reset)
			credits <= credit_width'(queue_depth);
		else
		begin
			case ({push, credit_up})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- pad_poll_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module pad_poll_sequencer
	import pad_proto_pkg::*;
#(
	parameter int latch_cycles = 12,
	parameter int half_bit_cycles = 6,
	parameter int poll_period_cycles = 400
)
(
	input  wire logic clock,
	input  wire logic reset,
	input  wire logic pad_data,
	output logic pad_latch,
	output logic pad_pulse,
	output logic frame_valid,
	output pad_frame_t frame
);

	localparam int count_width = $clog2(poll_period_cycles);
	// sixteen pulse phases follow the latch
	localparam int active_end = latch_cycles + 16 * half_bit_cycles;
	// falling edge of pulse for the right button
	localparam int last_sample = latch_cycles + 14 * half_bit_cycles;

	logic [count_width-1:0] count;
	logic [count_width-1:0] count_next;
	logic latch_next;
	logic pulse_next;
	logic data_meta;
	logic data_sync;
	logic sample_hit;
	button_state_t shift_reg;

	////////////////////////////////////////////////////////////
	// poll counter
	////////////////////////////////////////////////////////////

	// wraps once per poll period
	always_comb
	begin
		if (count == count_width'(poll_period_cycles - 1))
			count_next = '0;
		else
			count_next = count + 1'b1;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			count <= '0;
		else
			count <= count_next;
	end

	// latch and pulse decoded from the next count
	// so the registered outputs line up with the count itself
	always_comb
	begin
		latch_next = 1'b0;
		pulse_next = 1'b1;
		if (count_next < latch_cycles)
		begin
			latch_next = 1'b1;
			pulse_next = 1'b1;
		end
		else if (count_next < active_end)
		begin
			// even phases low, odd phases high
			for (int p = 0; p < 16; p++)
			begin
				if (count_next >= latch_cycles + p * half_bit_cycles &&
					count_next < latch_cycles + (p + 1) * half_bit_cycles)
					pulse_next = p[0];
			end
		end
	end

	// count is 0 after reset, so both lines start high
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pad_latch <= 1'b1;
			pad_pulse <= 1'b1;
		end
		else
		begin
			pad_latch <= latch_next;
			pad_pulse <= pulse_next;
		end
	end

	////////////////////////////////////////////////////////////
	// data capture
	////////////////////////////////////////////////////////////

	// two flop synchronizer on the pad line
	always_ff @(posedge clock)
	begin
		data_meta <= pad_data;
		data_sync <= data_meta;
	end

	// one sample at each falling edge of pulse
	always_comb
	begin
		sample_hit = 1'b0;
		for (int k = 0; k < num_buttons; k++)
		begin
			if (count == count_width'(latch_cycles + 2 * k * half_bit_cycles))
				sample_hit = 1'b1;
		end
	end

	// pad line is active low, A shifts in first and ends in the top bit
	always_ff @(posedge clock)
	begin
		if (sample_hit)
			shift_reg <= {shift_reg[num_buttons-2:0], ~data_sync};
	end

	// publish on the eighth sample, valid one cycle later
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			frame_valid <= 1'b0;
			frame <= '0;
		end
		else
		begin
			frame_valid <= 1'b0;
			if (count == count_width'(last_sample))
			begin
				frame_valid <= 1'b1;
				frame.buttons <= {shift_reg[num_buttons-2:0], ~data_sync};
				frame.seq <= frame.seq + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- pad_event_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////
// button change events
////////////////////////////////////////////////////////////

package pad_event_pkg;

	import pad_proto_pkg::*;

	// direction of a button change
	typedef enum logic
	{
		ev_release = 1'b0,
		ev_press   = 1'b1
	} event_kind_e;

	// one press or release, tagged with the frame that caused it
	// 12 bits: kind, button index, frame seq
	typedef struct packed
	{
		event_kind_e kind;
		button_index_e button;
		frame_seq_t seq;
	} pad_event_t;

endpackage

`default_nettype wire

//--- pad_proto_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////
// serial pad protocol types
////////////////////////////////////////////////////////////

package pad_proto_pkg;

	// eight buttons shifted out per poll
	localparam int num_buttons = 8;
	localparam int seq_width = 8;

	// bit positions inside a snapshot
	// A leaves the pad first and lands in the top bit
	typedef enum logic [2:0]
	{
		btn_right  = 3'd0,
		btn_left   = 3'd1,
		btn_down   = 3'd2,
		btn_up     = 3'd3,
		btn_start  = 3'd4,
		btn_select = 3'd5,
		btn_b      = 3'd6,
		btn_a      = 3'd7
	} button_index_e;

	// one bit per button, 1 means pressed
	typedef struct packed
	{
		logic a;
		logic b;
		logic select;
		logic start;
		logic up;
		logic down;
		logic left;
		logic right;
	} button_state_t;

	// frame number, wraps after 255 polls
	typedef logic [seq_width-1:0] frame_seq_t;

	// one completed poll
	typedef struct packed
	{
		button_state_t buttons;
		frame_seq_t seq;
	} pad_frame_t;

endpackage

`default_nettype wire
